// File: rtl/mem_sys_cfg.svh
`ifndef MEM_SYS_CFG_SVH
`define MEM_SYS_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Memory geometry
//////////////////////////////////////////////////////////////////////

// Width of one memory line in bits
`define MEM_DATA_WIDTH 64

// Instruction memory size in bytes
`define MEM_IMEM_BYTES 4096

// Single-cycle data memory size in bytes, split over two banks
`define MEM_FAST_BYTES 4096

// Broadcast region at the top of the fast memory
`define MEM_BC_REGION_BYTES 256

//////////////////////////////////////////////////////////////////////
// Queue depths
//////////////////////////////////////////////////////////////////////

// DMA request queues
`define MEM_REQ_FIFO_DEPTH 4

// DMA read response queue
`define MEM_RESP_FIFO_DEPTH 8

`endif

// File: rtl/mem_sys_pkg.sv
`include "mem_sys_cfg.svh"

package mem_sys_pkg;

  localparam int STRB_W          = `MEM_DATA_WIDTH / 8;
  localparam int LINE_ADDR_BITS  = $clog2(STRB_W);
  localparam int FAST_ADDR_BITS  = $clog2(`MEM_FAST_BYTES);
  localparam int IMEM_ADDR_BITS  = $clog2(`MEM_IMEM_BYTES);
  localparam int IMEM_LINES      = `MEM_IMEM_BYTES / STRB_W;
  localparam int FAST_BANK_LINES = `MEM_FAST_BYTES / STRB_W / 2;
  localparam int BC_WORD_BITS    = $clog2(`MEM_BC_REGION_BYTES) - 2;

  // Top address bit selects the instruction memory
  localparam int ADDR_BITS = ((IMEM_ADDR_BITS > FAST_ADDR_BITS) ?
                              IMEM_ADDR_BITS : FAST_ADDR_BITS) + 1;

  // Line index is sized for the largest RAM, the instruction memory
  localparam int LINE_IDX_BITS = ($clog2(IMEM_LINES) > $clog2(FAST_BANK_LINES)) ?
                                 $clog2(IMEM_LINES) : $clog2(FAST_BANK_LINES);

  typedef logic [`MEM_DATA_WIDTH-1:0] line_t;
  typedef logic [STRB_W-1:0]          strb_t;
  typedef logic [ADDR_BITS-1:0]       addr_t;
  typedef logic [FAST_ADDR_BITS-1:0]  fast_addr_t;
  typedef logic [LINE_IDX_BITS-1:0]   bank_line_t;
  typedef logic [BC_WORD_BITS-1:0]    bc_word_t;

  localparam fast_addr_t BC_START_ADDR =
    fast_addr_t'(`MEM_FAST_BYTES - `MEM_BC_REGION_BYTES);

  typedef struct packed {
    addr_t addr;
    strb_t strb;
    line_t data;
  } dma_wr_cmd_t;

  typedef struct packed {
    fast_addr_t addr;
  } dma_rd_cmd_t;

  typedef struct packed {
    bc_word_t    addr;
    logic [3:0]  strb;
    logic [31:0] data;
  } bc_msg_t;

  typedef struct packed {
    logic       en;
    logic       rd;
    bank_line_t line;
    strb_t      strb;
    line_t      data;
  } bank_req_t;

  // Line inside a fast bank; the bit below it picks the bank
  function automatic bank_line_t fast_line(fast_addr_t addr);
    return bank_line_t'(addr[FAST_ADDR_BITS-1:LINE_ADDR_BITS+1]);
  endfunction

endpackage

// File: rtl/req_fifo.sv
module req_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output logic     full,
  output logic     almost_full,
  output logic     empty,
  output payload_t dout
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t            slots [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   count;

  always_ff @(posedge clk) begin
    if (push) begin
      slots[wr_ptr] <= din;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign full        = (count == (PTR_BITS + 1)'(DEPTH));
  // Fewer than two free entries
  assign almost_full = (count >= (PTR_BITS + 1)'(DEPTH - 1));
  assign empty       = (count == '0);
  assign dout        = slots[rd_ptr];

  no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("req_fifo push while full");

  no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
    else $error("req_fifo pop while empty");

endmodule

// File: rtl/bc_msg_align.sv
module bc_msg_align (
  input  logic                  clk,
  input  logic                  rst,
  input  mem_sys_pkg::bc_msg_t  msg,
  input  logic                  msg_valid,
  output mem_sys_pkg::bank_req_t req,
  output logic                  bank
);
  import mem_sys_pkg::*;

  localparam int LANE_BITS = LINE_ADDR_BITS - 2;

  bc_msg_t    msg_q;
  logic       valid_q;
  fast_addr_t addr_q2;
  strb_t      strb_q2;
  line_t      data_q2;
  logic       valid_q2;

  // Stage one, capture the message as it arrives
  always_ff @(posedge clk) begin
    msg_q <= msg;
  end

  // Stage two, place the word in the region and move it to its lane
  always_ff @(posedge clk) begin
    addr_q2 <= fast_addr_t'({msg_q.addr, 2'b00}) + BC_START_ADDR;
    strb_q2 <= strb_t'(msg_q.strb) << {msg_q.addr[LANE_BITS-1:0], 2'b00};
    data_q2 <= line_t'(msg_q.data) << {msg_q.addr[LANE_BITS-1:0], 5'b00000};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= 1'b0;
      valid_q2 <= 1'b0;
    end else begin
      valid_q  <= msg_valid;
      valid_q2 <= valid_q;
    end
  end

  assign req.en   = valid_q2;
  assign req.rd   = 1'b0;
  assign req.line = fast_line(addr_q2);
  assign req.strb = strb_q2;
  assign req.data = data_q2;
  assign bank     = addr_q2[LINE_ADDR_BITS];

endmodule

// File: rtl/fast_bank_arb.sv
module fast_bank_arb #(
  parameter int BANK = 0
) (
  input  mem_sys_pkg::bank_req_t   bc_req,
  input  logic                     bc_bank,
  input  mem_sys_pkg::dma_wr_cmd_t wr_cmd,
  input  logic                     wr_valid,
  input  mem_sys_pkg::dma_rd_cmd_t rd_cmd,
  input  logic                     rd_valid,
  input  logic                     resp_room,
  output mem_sys_pkg::bank_req_t   port_req,
  output logic                     wr_gnt,
  output logic                     rd_gnt
);
  import mem_sys_pkg::*;

  localparam logic BANK_BIT = 1'(BANK);

  fast_addr_t wr_addr;
  logic       bc_hit;
  logic       wr_hit;
  logic       rd_hit;

  // Write queue only holds fast memory commands
  assign wr_addr = fast_addr_t'(wr_cmd.addr);

  assign bc_hit = bc_req.en && (bc_bank == BANK_BIT);
  assign wr_hit = wr_valid && (wr_addr[LINE_ADDR_BITS] == BANK_BIT);
  // A read also needs space for its data in the response queue
  assign rd_hit = rd_valid && (rd_cmd.addr[LINE_ADDR_BITS] == BANK_BIT) && resp_room;

  // Broadcast first so the message network never backs up,
  // then DMA writes, then DMA reads
  always_comb begin
    port_req      = '0;
    port_req.line = fast_line(wr_addr);
    port_req.data = wr_cmd.data;
    wr_gnt        = 1'b0;
    rd_gnt        = 1'b0;

    if (bc_hit) begin
      port_req = bc_req;
    end else if (wr_hit) begin
      port_req.en   = 1'b1;
      port_req.strb = wr_cmd.strb;
      wr_gnt        = 1'b1;
    end else if (rd_hit) begin
      port_req.en   = 1'b1;
      port_req.rd   = 1'b1;
      port_req.line = fast_line(rd_cmd.addr);
      rd_gnt        = 1'b1;
    end
  end

endmodule

// File: rtl/bank_ram.sv
module bank_ram #(
  parameter int LINES = 256
) (
  input  logic                    clk,
  input  mem_sys_pkg::bank_req_t  a_req,
  input  logic                    b_en,
  input  mem_sys_pkg::strb_t      b_wen,
  input  mem_sys_pkg::bank_line_t b_line,
  input  mem_sys_pkg::line_t      b_data,
  output mem_sys_pkg::line_t      a_rdata,
  output mem_sys_pkg::line_t      b_rdata
);
  import mem_sys_pkg::*;

  localparam int IDX_BITS = $clog2(LINES);

  line_t               mem [LINES];
  logic [IDX_BITS-1:0] a_idx;
  logic [IDX_BITS-1:0] b_idx;

  assign a_idx = a_req.line[IDX_BITS-1:0];
  assign b_idx = b_line[IDX_BITS-1:0];

  // Byte writes on both ports, port B lands last on a collision
  always_ff @(posedge clk) begin
    for (int i = 0; i < STRB_W; i++) begin
      if (a_req.en && !a_req.rd && a_req.strb[i]) begin
        mem[a_idx][i*8 +: 8] <= a_req.data[i*8 +: 8];
      end
      if (b_en && b_wen[i]) begin
        mem[b_idx][i*8 +: 8] <= b_data[i*8 +: 8];
      end
    end
  end

  // Registered reads, old data on a same-cycle write
  always_ff @(posedge clk) begin
    if (a_req.en && a_req.rd) begin
      a_rdata <= mem[a_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (b_en) begin
      b_rdata <= mem[b_idx];
    end
  end

endmodule

// File: rtl/mem_sys.sv
`include "mem_sys_cfg.svh"

module mem_sys (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     dma_cmd_wr_en,
  input  mem_sys_pkg::dma_wr_cmd_t dma_cmd_wr,
  output logic                     dma_cmd_wr_ready,

  input  logic                     dma_cmd_rd_en,
  input  mem_sys_pkg::dma_rd_cmd_t dma_cmd_rd,
  output logic                     dma_cmd_rd_ready,

  output logic                     dma_rd_resp_valid,
  output mem_sys_pkg::line_t       dma_rd_resp_data,
  input  logic                     dma_rd_resp_ready,

  input  logic                     core_dmem_en,
  input  mem_sys_pkg::strb_t       core_dmem_wen,
  input  mem_sys_pkg::addr_t       core_dmem_addr,
  input  mem_sys_pkg::line_t       core_dmem_wr_data,
  output mem_sys_pkg::line_t       core_dmem_rd_data,
  output logic                     core_dmem_rd_valid,

  input  logic                     core_imem_ren,
  input  mem_sys_pkg::addr_t       core_imem_addr,
  output mem_sys_pkg::line_t       core_imem_rd_data,

  input  mem_sys_pkg::bc_msg_t     bc_msg_in,
  input  logic                     bc_msg_in_valid
);
  import mem_sys_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // DMA request decode and queues
  //////////////////////////////////////////////////////////////////////

  logic        dma_wr_fire;
  logic        imem_wr_push;
  logic        fast_wr_push;
  logic        fast_wr_full;
  logic        fast_wr_empty;
  dma_wr_cmd_t fast_wr_head;
  logic        imem_wr_empty;
  dma_wr_cmd_t imem_wr_head;
  logic        rd_push;
  logic        rd_full;
  logic        rd_empty;
  dma_rd_cmd_t rd_head;
  logic [1:0]  wr_gnt;
  logic [1:0]  rd_gnt;

  assign dma_wr_fire  = dma_cmd_wr_en && dma_cmd_wr_ready;
  assign imem_wr_push = dma_wr_fire && dma_cmd_wr.addr[ADDR_BITS-1];
  assign fast_wr_push = dma_wr_fire && !dma_cmd_wr.addr[ADDR_BITS-1];
  assign rd_push      = dma_cmd_rd_en && dma_cmd_rd_ready;

  // Instruction memory takes a write every cycle, so this queue drains at once
  req_fifo #(.payload_t(dma_wr_cmd_t), .DEPTH(`MEM_REQ_FIFO_DEPTH)) u_imem_wr_fifo (
    .clk         (clk),
    .rst         (rst),
    .push        (imem_wr_push),
    .din         (dma_cmd_wr),
    .pop         (!imem_wr_empty),
    .full        (),
    .almost_full (),
    .empty       (imem_wr_empty),
    .dout        (imem_wr_head)
  );

  req_fifo #(.payload_t(dma_wr_cmd_t), .DEPTH(`MEM_REQ_FIFO_DEPTH)) u_fast_wr_fifo (
    .clk         (clk),
    .rst         (rst),
    .push        (fast_wr_push),
    .din         (dma_cmd_wr),
    .pop         (|wr_gnt),
    .full        (fast_wr_full),
    .almost_full (),
    .empty       (fast_wr_empty),
    .dout        (fast_wr_head)
  );

  req_fifo #(.payload_t(dma_rd_cmd_t), .DEPTH(`MEM_REQ_FIFO_DEPTH)) u_fast_rd_fifo (
    .clk         (clk),
    .rst         (rst),
    .push        (rd_push),
    .din         (dma_cmd_rd),
    .pop         (|rd_gnt),
    .full        (rd_full),
    .almost_full (),
    .empty       (rd_empty),
    .dout        (rd_head)
  );

  assign dma_cmd_wr_ready = !fast_wr_full;
  assign dma_cmd_rd_ready = !rd_full;

  //////////////////////////////////////////////////////////////////////
  // Broadcast path and fast banks
  //////////////////////////////////////////////////////////////////////

  bank_req_t bc_req;
  logic      bc_bank;
  logic      resp_almost_full;
  logic      core_bank;
  bank_line_t core_line;
  line_t     a_rdata [2];
  line_t     b_rdata [2];

  bc_msg_align u_bc_align (
    .clk       (clk),
    .rst       (rst),
    .msg       (bc_msg_in),
    .msg_valid (bc_msg_in_valid),
    .req       (bc_req),
    .bank      (bc_bank)
  );

  // Core reaches the same line index in either bank
  assign core_bank = core_dmem_addr[LINE_ADDR_BITS];
  assign core_line = fast_line(fast_addr_t'(core_dmem_addr));

  for (genvar b = 0; b < 2; b++) begin : g_bank
    bank_req_t port_req;

    fast_bank_arb #(.BANK(b)) u_arb (
      .bc_req    (bc_req),
      .bc_bank   (bc_bank),
      .wr_cmd    (fast_wr_head),
      .wr_valid  (!fast_wr_empty),
      .rd_cmd    (rd_head),
      .rd_valid  (!rd_empty),
      .resp_room (!resp_almost_full),
      .port_req  (port_req),
      .wr_gnt    (wr_gnt[b]),
      .rd_gnt    (rd_gnt[b])
    );

    bank_ram #(.LINES(FAST_BANK_LINES)) u_ram (
      .clk     (clk),
      .a_req   (port_req),
      .b_en    (core_dmem_en && (core_bank == 1'(b))),
      .b_wen   (core_dmem_wen),
      .b_line  (core_line),
      .b_data  (core_dmem_wr_data),
      .a_rdata (a_rdata[b]),
      .b_rdata (b_rdata[b])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Instruction memory
  //////////////////////////////////////////////////////////////////////

  bank_req_t imem_req;

  assign imem_req.en   = !imem_wr_empty;
  assign imem_req.rd   = 1'b0;
  assign imem_req.line = bank_line_t'(imem_wr_head.addr[IMEM_ADDR_BITS-1:LINE_ADDR_BITS]);
  assign imem_req.strb = imem_wr_head.strb;
  assign imem_req.data = imem_wr_head.data;

  // Port A writes from DMA, port B is the fetch port
  bank_ram #(.LINES(IMEM_LINES)) u_imem (
    .clk     (clk),
    .a_req   (imem_req),
    .b_en    (core_imem_ren),
    .b_wen   ('0),
    .b_line  (bank_line_t'(core_imem_addr[IMEM_ADDR_BITS-1:LINE_ADDR_BITS])),
    .b_data  ('0),
    .a_rdata (),
    .b_rdata (core_imem_rd_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Read response steering
  //////////////////////////////////////////////////////////////////////

  logic  rd_gnt_q;
  logic  rd_bank_q;
  logic  core_rd_q;
  logic  core_bank_q;
  logic  resp_empty;
  line_t resp_din;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_gnt_q    <= 1'b0;
      rd_bank_q   <= 1'b0;
      core_rd_q   <= 1'b0;
      core_bank_q <= 1'b0;
    end else begin
      rd_gnt_q    <= |rd_gnt;
      rd_bank_q   <= rd_gnt[1];
      core_rd_q   <= core_dmem_en && !(|core_dmem_wen);
      core_bank_q <= core_bank;
    end
  end

  assign resp_din = rd_bank_q ? a_rdata[1] : a_rdata[0];

  // Reads are only granted with two free entries, so this never overflows
  req_fifo #(.payload_t(line_t), .DEPTH(`MEM_RESP_FIFO_DEPTH)) u_resp_fifo (
    .clk         (clk),
    .rst         (rst),
    .push        (rd_gnt_q),
    .din         (resp_din),
    .pop         (dma_rd_resp_valid && dma_rd_resp_ready),
    .full        (),
    .almost_full (resp_almost_full),
    .empty       (resp_empty),
    .dout        (dma_rd_resp_data)
  );

  assign dma_rd_resp_valid  = !resp_empty;
  assign core_dmem_rd_valid = core_rd_q;
  assign core_dmem_rd_data  = core_bank_q ? b_rdata[1] : b_rdata[0];

endmodule

// File: bench/mem_sys_tb_checks.svh
`ifndef MEM_SYS_TB_CHECKS_SVH
`define MEM_SYS_TB_CHECKS_SVH

int    error_count  = 0;
int    errors_before = 0;
int    tests_run    = 0;
int    tests_failed = 0;
string test_name    = "";

task automatic check_line(line_t got, line_t exp, string what);
  if (got !== exp) begin
    $display("** Error @ %0t: %s got %h, expected %h", $time, what, got, exp);
    error_count++;
  end
endtask

task automatic check_flag(logic got, logic exp, string what);
  if (got !== exp) begin
    $display("** Error @ %0t: %s got %b, expected %b", $time, what, got, exp);
    error_count++;
  end
endtask

// Failures that are not a wrong value, such as a missing or extra response
task automatic note_failure(string what);
  $display("Failure at time %0t: %s", $time, what);
  error_count++;
endtask

task automatic start_test(string name);
  test_name     = name;
  errors_before = error_count;
  tests_run++;
endtask

task automatic finish_test();
  int n;
  n = error_count - errors_before;
  if (n == 0) begin
    $display("Test %s: ok", test_name);
  end else begin
    $display("Test %s: %0d errors", test_name, n);
    tests_failed++;
  end
endtask

`endif

// File: bench/mem_sys_tb.sv
`include "mem_sys_cfg.svh"

module mem_sys_tb;
  import mem_sys_pkg::*;

  localparam int BYTES_PER_LINE   = `MEM_DATA_WIDTH / 8;
  localparam int FAST_MODEL_LINES = `MEM_FAST_BYTES / BYTES_PER_LINE;
  localparam int IMEM_MODEL_LINES = `MEM_IMEM_BYTES / BYTES_PER_LINE;
  localparam int BC_BASE          = `MEM_FAST_BYTES - `MEM_BC_REGION_BYTES;
  localparam int TOP_BIT          = $bits(addr_t) - 1;
  localparam int WAIT_LIMIT       = 200;

  typedef enum int {READY_HIGH, READY_LOW, READY_RANDOM} ready_mode_t;

  logic        clk;
  logic        rst;
  logic        dma_cmd_wr_en;
  dma_wr_cmd_t dma_cmd_wr;
  logic        dma_cmd_wr_ready;
  logic        dma_cmd_rd_en;
  dma_rd_cmd_t dma_cmd_rd;
  logic        dma_cmd_rd_ready;
  logic        dma_rd_resp_valid;
  line_t       dma_rd_resp_data;
  logic        dma_rd_resp_ready;
  logic        core_dmem_en;
  strb_t       core_dmem_wen;
  addr_t       core_dmem_addr;
  line_t       core_dmem_wr_data;
  line_t       core_dmem_rd_data;
  logic        core_dmem_rd_valid;
  logic        core_imem_ren;
  addr_t       core_imem_addr;
  line_t       core_imem_rd_data;
  bc_msg_t     bc_msg_in;
  logic        bc_msg_in_valid;

  // Model memories and expected responses in issue order
  line_t        fast_model [FAST_MODEL_LINES];
  line_t        imem_model [IMEM_MODEL_LINES];
  line_t        exp_dma_q [$];
  line_t        exp_core_q [$];
  line_t        exp_imem_q [$];
  fast_addr_t   test_addrs [$];
  integer       seed       = 76749;
  ready_mode_t  ready_mode = READY_HIGH;
  logic         core_rd_issued;
  logic         imem_rd_issued;

  `include "mem_sys_tb_checks.svh"

  mem_sys u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic line_t ref_line_merge(line_t old_line, line_t new_data, strb_t strb);
    line_t result;
    result = old_line;
    for (int i = 0; i < BYTES_PER_LINE; i++) begin
      if (strb[i]) begin
        result[i*8 +: 8] = new_data[i*8 +: 8];
      end
    end
    return result;
  endfunction

  function automatic int fast_line_of(addr_t addr);
    return (int'(addr) % `MEM_FAST_BYTES) / BYTES_PER_LINE;
  endfunction

  function automatic int imem_line_of(addr_t addr);
    return (int'(addr) % `MEM_IMEM_BYTES) / BYTES_PER_LINE;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Response ready and comparing process
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    case (ready_mode)
      READY_RANDOM: dma_rd_resp_ready <= 1'($random(seed));
      READY_LOW:    dma_rd_resp_ready <= 1'b0;
      default:      dma_rd_resp_ready <= 1'b1;
    endcase
  end

  // Which core reads the DUT took on each edge
  always @(posedge clk) begin
    if (rst) begin
      core_rd_issued <= 1'b0;
      imem_rd_issued <= 1'b0;
    end else begin
      core_rd_issued <= core_dmem_en && (core_dmem_wen == '0);
      imem_rd_issued <= core_imem_ren;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      check_flag(core_dmem_rd_valid, core_rd_issued, "core_dmem_rd_valid");
      if (core_dmem_rd_valid) begin
        if (exp_core_q.size() == 0) begin
          note_failure("core read data arrived with no read outstanding");
        end else begin
          check_line(core_dmem_rd_data, exp_core_q.pop_front(), "core read data");
        end
      end
      if (imem_rd_issued) begin
        if (exp_imem_q.size() == 0) begin
          note_failure("instruction read with no expected data");
        end else begin
          check_line(core_imem_rd_data, exp_imem_q.pop_front(), "imem read data");
        end
      end
      // A response leaves on the next edge when valid and ready are both high
      if (dma_rd_resp_valid && dma_rd_resp_ready) begin
        if (exp_dma_q.size() == 0) begin
          note_failure("DMA read response with no read outstanding");
        end else begin
          check_line(dma_rd_resp_data, exp_dma_q.pop_front(), "DMA read data");
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(string why);
    $display("Timeout at time %0t: %s", $time, why);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic settle(int cycles);
    repeat (cycles) @(posedge clk);
  endtask

  task automatic dma_write(addr_t addr, strb_t strb, line_t data);
    dma_wr_cmd_t cmd;
    int          waited;
    int          idx;
    cmd.addr = addr;
    cmd.strb = strb;
    cmd.data = data;
    waited   = 0;
    @(posedge clk);
    dma_cmd_wr_en <= 1'b1;
    dma_cmd_wr    <= cmd;
    @(negedge clk);
    while (!dma_cmd_wr_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("DMA write command never accepted");
      end
      @(negedge clk);
    end
    // Accepted on the coming edge
    if (addr[TOP_BIT]) begin
      idx = imem_line_of(addr);
      imem_model[idx] = ref_line_merge(imem_model[idx], data, strb);
    end else begin
      idx = fast_line_of(addr);
      fast_model[idx] = ref_line_merge(fast_model[idx], data, strb);
    end
    @(posedge clk);
    dma_cmd_wr_en <= 1'b0;
  endtask

  task automatic dma_read(fast_addr_t addr);
    dma_rd_cmd_t cmd;
    int          waited;
    cmd.addr = addr;
    waited   = 0;
    @(posedge clk);
    dma_cmd_rd_en <= 1'b1;
    dma_cmd_rd    <= cmd;
    @(negedge clk);
    while (!dma_cmd_rd_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("DMA read command never accepted");
      end
      @(negedge clk);
    end
    exp_dma_q.push_back(fast_model[fast_line_of(addr_t'(addr))]);
    @(posedge clk);
    dma_cmd_rd_en <= 1'b0;
  endtask

  // Core requests go back to back until core_idle
  task automatic core_access(addr_t addr, strb_t wen, line_t data);
    int idx;
    idx = fast_line_of(addr);
    @(posedge clk);
    core_dmem_en      <= 1'b1;
    core_dmem_wen     <= wen;
    core_dmem_addr    <= addr;
    core_dmem_wr_data <= data;
    if (wen == '0) begin
      exp_core_q.push_back(fast_model[idx]);
    end else begin
      fast_model[idx] = ref_line_merge(fast_model[idx], data, wen);
    end
  endtask

  task automatic core_idle();
    @(posedge clk);
    core_dmem_en  <= 1'b0;
    core_dmem_wen <= '0;
  endtask

  task automatic wait_drain(string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_dma_q.size() + exp_core_q.size() + exp_imem_q.size() != 0) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run({"responses missing for ", what});
      end
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    start_test("reset state");
    @(negedge clk);
    check_flag(dma_rd_resp_valid, 1'b0, "dma_rd_resp_valid after reset");
    check_flag(core_dmem_rd_valid, 1'b0, "core_dmem_rd_valid after reset");
    check_flag(dma_cmd_wr_ready, 1'b1, "dma_cmd_wr_ready after reset");
    check_flag(dma_cmd_rd_ready, 1'b1, "dma_cmd_rd_ready after reset");
    finish_test();
  endtask

  task automatic test_dma_write_core_read();
    int idx;
    start_test("dma write, core read");
    // Even and odd lines alternate so both banks are hit, all below the region
    for (int i = 0; i < 16; i++) begin
      idx = {$random(seed)} % (BC_BASE / BYTES_PER_LINE / 2);
      test_addrs.push_back(fast_addr_t'((idx * 2 + i % 2) * BYTES_PER_LINE));
      dma_write(addr_t'(test_addrs[i]), '1, {$random(seed), $random(seed)});
    end
    settle(8);
    foreach (test_addrs[i]) begin
      core_access(addr_t'(test_addrs[i]), '0, '0);
    end
    core_idle();
    wait_drain("core reads");
    finish_test();
  endtask

  task automatic test_core_store_dma_read();
    fast_addr_t rd_addrs [$];
    strb_t      wen;
    start_test("core store, dma read");
    foreach (test_addrs[i]) begin
      wen = strb_t'($random(seed));
      if (wen == '0) begin
        wen = 8'h81;
      end
      core_access(addr_t'(test_addrs[i]), wen, {$random(seed), $random(seed)});
    end
    core_idle();
    for (int i = 0; i < 24; i++) begin
      rd_addrs.push_back(test_addrs[{$random(seed)} % test_addrs.size()]);
    end
    @(negedge clk);
    ready_mode = READY_RANDOM;
    foreach (rd_addrs[i]) begin
      dma_read(rd_addrs[i]);
    end
    wait_drain("DMA reads");
    ready_mode = READY_HIGH;
    finish_test();
  endtask

  task automatic test_broadcast();
    bc_msg_t msg;
    int      byte_addr;
    int      idx;
    int      lane;
    start_test("broadcast");
    // Region gets known contents first, each line tagged with its address
    for (int a = BC_BASE; a < `MEM_FAST_BYTES; a += BYTES_PER_LINE) begin
      dma_write(addr_t'(a), '1, {4{16'(a) ^ 16'h5a00}});
    end
    settle(8);
    for (int i = 0; i < 24; i++) begin
      msg.addr  = bc_word_t'($random(seed));
      msg.strb  = 4'($random(seed));
      msg.data  = $random(seed);
      byte_addr = BC_BASE + 4 * msg.addr;
      idx       = byte_addr / BYTES_PER_LINE;
      lane      = (byte_addr / 4) % (BYTES_PER_LINE / 4);
      fast_model[idx] = ref_line_merge(fast_model[idx], line_t'(msg.data) << (32 * lane),
                                       strb_t'(msg.strb) << (4 * lane));
      @(posedge clk);
      bc_msg_in       <= msg;
      bc_msg_in_valid <= 1'b1;
    end
    @(posedge clk);
    bc_msg_in_valid <= 1'b0;
    // Last word lands two cycles after its valid
    settle(4);
    for (int a = BC_BASE; a < `MEM_FAST_BYTES; a += BYTES_PER_LINE) begin
      core_access(addr_t'(a), '0, '0);
    end
    core_idle();
    wait_drain("broadcast read back");
    finish_test();
  endtask

  task automatic test_imem();
    addr_t imem_addrs [$];
    addr_t addr;
    start_test("instruction memory");
    for (int i = 0; i < 12; i++) begin
      addr = addr_t'(({$random(seed)} % IMEM_MODEL_LINES) * BYTES_PER_LINE);
      addr[TOP_BIT] = 1'b1;
      imem_addrs.push_back(addr);
      dma_write(addr, '1, {$random(seed), $random(seed)});
    end
    settle(8);
    foreach (imem_addrs[i]) begin
      @(posedge clk);
      core_imem_ren  <= 1'b1;
      core_imem_addr <= imem_addrs[i];
      exp_imem_q.push_back(imem_model[imem_line_of(imem_addrs[i])]);
    end
    @(posedge clk);
    core_imem_ren <= 1'b0;
    wait_drain("instruction reads");
    finish_test();
  endtask

  task automatic test_read_backpressure();
    dma_rd_cmd_t cmd;
    fast_addr_t  addr;
    logic        stalled;
    @(negedge clk);
    start_test("read back-pressure");
    ready_mode = READY_LOW;
    @(posedge clk);
    stalled = 1'b0;
    for (int n = 0; n < 40 && !stalled; n++) begin
      addr     = test_addrs[n % test_addrs.size()];
      cmd.addr = addr;
      @(posedge clk);
      dma_cmd_rd_en <= 1'b1;
      dma_cmd_rd    <= cmd;
      @(negedge clk);
      if (dma_cmd_rd_ready) begin
        exp_dma_q.push_back(fast_model[fast_line_of(addr_t'(addr))]);
      end else begin
        stalled = 1'b1;
      end
    end
    @(posedge clk);
    dma_cmd_rd_en <= 1'b0;
    if (!stalled) begin
      note_failure("dma_cmd_rd_ready never fell while responses were held");
    end
    repeat (4) @(negedge clk);
    check_flag(dma_rd_resp_valid, 1'b1, "dma_rd_resp_valid while held");
    ready_mode = READY_HIGH;
    wait_drain("held DMA reads");
    repeat (3) @(negedge clk);
    check_flag(dma_rd_resp_valid, 1'b0, "dma_rd_resp_valid after drain");
    finish_test();
  endtask

  initial begin
    rst               = 1'b1;
    dma_cmd_wr_en     = 1'b0;
    dma_cmd_wr        = '0;
    dma_cmd_rd_en     = 1'b0;
    dma_cmd_rd        = '0;
    dma_rd_resp_ready = 1'b1;
    core_dmem_en      = 1'b0;
    core_dmem_wen     = '0;
    core_dmem_addr    = '0;
    core_dmem_wr_data = '0;
    core_imem_ren     = 1'b0;
    core_imem_addr    = '0;
    bc_msg_in         = '0;
    bc_msg_in_valid   = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    test_reset_state();
    test_dma_write_core_read();
    test_core_store_dma_read();
    test_broadcast();
    test_imem();
    test_read_backpressure();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+rtl
+incdir+bench
rtl/mem_sys_pkg.sv
rtl/req_fifo.sv
rtl/bc_msg_align.sv
rtl/fast_bank_arb.sv
rtl/bank_ram.sv
rtl/mem_sys.sv
bench/mem_sys_tb.sv

// File: Bender.yml
package:
  name: mem_sys

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_sys_pkg.sv
      - rtl/req_fifo.sv
      - rtl/bc_msg_align.sv
      - rtl/fast_bank_arb.sv
      - rtl/bank_ram.sv
      - rtl/mem_sys.sv

  - target: test
    include_dirs:
      - rtl
      - bench
    files:
      - bench/mem_sys_tb.sv
